// ==== Bender.yml ====
package:
  name: soc_periph

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/soc_periph_pkg.sv
      - hw/apb_decoder.sv
      - hw/button_irq.sv
      - gpio/gpio_port.sv
      - uart/uart_core.sv
      - hw/soc_periph_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - tests/soc_periph_assertions.sv
      - tests/soc_periph_tb.sv

// ==== common/soc_periph_defines.svh ====
`ifndef SOC_PERIPH_DEFINES_SVH
`define SOC_PERIPH_DEFINES_SVH

// ---------------------------------------------------------------------------
// APB bus geometry
// ---------------------------------------------------------------------------
`define DATA_WIDTH 32
`define ADDR_WIDTH 12

// Peripheral region select bits in paddr
`define REGION_MSB 9
`define REGION_LSB 8

// ---------------------------------------------------------------------------
// Peripheral sizes
// ---------------------------------------------------------------------------
`define GPIO_WIDTH 16
`define BTN_WIDTH  4

// Interrupt vector, buttons sit in the low bits
`define IRQ_WIDTH   5
`define IRQ_UART_RX 4

// ---------------------------------------------------------------------------
// UART
// ---------------------------------------------------------------------------
`define UART_BAUDDIV_WIDTH 16
`define UART_BAUDDIV_RESET 16   // Clocks per bit out of reset

`endif

// ==== common/soc_periph_pkg.sv ====
`default_nettype none

package soc_periph_pkg;

    // Peripheral regions, decoded from paddr[9:8]
    typedef enum logic [1:0] {
        SEL_GPIO = 2'd0,
        SEL_UART = 2'd1,
        SEL_BTN  = 2'd2,
        SEL_NONE = 2'd3    // Unmapped, answers with pslverr
    } periph_sel_e;

    // Word offsets inside a region
    // Each peripheral gives these its own meaning
    typedef enum logic [7:0] {
        REG_0 = 8'h00,
        REG_1 = 8'h04,
        REG_2 = 8'h08
    } reg_off_e;

endpackage

`default_nettype wire

// ==== gpio/gpio_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defines.svh"

module gpio_port (
    input  logic                   sysclk,
    input  logic                   RSTn,
    input  logic                   sel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             addr,
    input  logic [`DATA_WIDTH-1:0] wdata,
    output logic [`DATA_WIDTH-1:0] rdata,
    inout  wire  [`GPIO_WIDTH-1:0] gpio
);

    import soc_periph_pkg::*;

    // REG_0 DATA_OUT (rw), REG_1 OUT_EN (rw), REG_2 DATA_IN (ro)
    logic [`GPIO_WIDTH-1:0] data_out;
    logic [`GPIO_WIDTH-1:0] out_en;
    logic [`GPIO_WIDTH-1:0] in_meta, data_in;
    logic                   wr_en;

    assign wr_en = sel && penable && pwrite;

    // -------------------------------------------------------------------------
    // Register writes
    // -------------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge RSTn) begin
        if (!RSTn) begin
            data_out <= '0;
            out_en   <= '0;     // All pins released
        end else if (wr_en) begin
            case (addr)
                REG_0:   data_out <= wdata[`GPIO_WIDTH-1:0];
                REG_1:   out_en   <= wdata[`GPIO_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // Input synchronizer, pins are asynchronous to sysclk
    always_ff @(posedge sysclk or negedge RSTn) begin
        if (!RSTn) begin
            in_meta <= '0;
            data_in <= '0;
        end else begin
            in_meta <= gpio;
            data_in <= in_meta;
        end
    end

    // -------------------------------------------------------------------------
    // Read mux
    // -------------------------------------------------------------------------
    always_comb begin
        rdata = '0;
        case (addr)
            REG_0:   rdata[`GPIO_WIDTH-1:0] = data_out;
            REG_1:   rdata[`GPIO_WIDTH-1:0] = out_en;
            REG_2:   rdata[`GPIO_WIDTH-1:0] = data_in;
            default: rdata = '0;
        endcase
    end

    // Pin drivers
    for (genvar i = 0; i < `GPIO_WIDTH; i++) begin : g_pin
        assign gpio[i] = out_en[i] ? data_out[i] : 1'bz;
    end

endmodule

`default_nettype wire

// ==== hw/apb_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defines.svh"

module apb_decoder (
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic [`REGION_MSB-`REGION_LSB:0]     region,
    input  logic [`DATA_WIDTH-1:0]               gpio_rdata,
    input  logic [`DATA_WIDTH-1:0]               uart_rdata,
    input  logic                                 uart_err,
    input  logic [`DATA_WIDTH-1:0]               btn_rdata,
    output logic                                 gpio_sel,
    output logic                                 uart_sel,
    output logic                                 btn_sel,
    output logic [`DATA_WIDTH-1:0]               prdata,
    output logic                                 pready,
    output logic                                 pslverr
);

    import soc_periph_pkg::*;

    periph_sel_e region_sel;

    assign region_sel = periph_sel_e'(region);

    // One-hot slave selects
    assign gpio_sel = psel && (region_sel == SEL_GPIO);
    assign uart_sel = psel && (region_sel == SEL_UART);
    assign btn_sel  = psel && (region_sel == SEL_BTN);

    // No wait states anywhere
    assign pready = 1'b1;

    // Read data and error return
    always_comb begin
        prdata  = '0;
        pslverr = 1'b0;
        unique case (region_sel)
            SEL_GPIO: prdata = gpio_rdata;
            SEL_UART: begin
                prdata  = uart_rdata;
                pslverr = uart_err;     // Already qualified by the access cycle
            end
            SEL_BTN:  prdata = btn_rdata;
            SEL_NONE: pslverr = psel && penable;    // Unmapped hole
            default:  prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/button_irq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defines.svh"

module button_irq (
    input  logic                   sysclk,
    input  logic                   RSTn,
    input  logic                   sel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             addr,
    input  logic [`DATA_WIDTH-1:0] wdata,
    output logic [`DATA_WIDTH-1:0] rdata,
    input  logic [`BTN_WIDTH-1:0]  btn,
    output logic [`BTN_WIDTH-1:0]  btn_irq
);

    import soc_periph_pkg::*;

    // REG_0 LEVEL (ro), REG_1 PENDING (w1c), REG_2 ENABLE (rw)
    logic [`BTN_WIDTH-1:0] btn_meta, btn_sync, btn_prev;
    logic [`BTN_WIDTH-1:0] pending, enable;
    logic [`BTN_WIDTH-1:0] rise;
    logic                  wr_en;

    assign wr_en = sel && penable && pwrite;
    assign rise  = btn_sync & ~btn_prev;

    always_ff @(posedge sysclk or negedge RSTn) begin
        if (!RSTn) begin
            btn_meta <= '0;
            btn_sync <= '0;
            btn_prev <= '0;
            pending  <= '0;
            enable   <= '0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
            // New edge wins over a clear in the same cycle
            if (wr_en && addr == REG_1)
                pending <= (pending & ~wdata[`BTN_WIDTH-1:0]) | rise;
            else
                pending <= pending | rise;
            if (wr_en && addr == REG_2)
                enable <= wdata[`BTN_WIDTH-1:0];
        end
    end

    always_comb begin
        rdata = '0;
        case (addr)
            REG_0:   rdata[`BTN_WIDTH-1:0] = btn_sync;
            REG_1:   rdata[`BTN_WIDTH-1:0] = pending;
            REG_2:   rdata[`BTN_WIDTH-1:0] = enable;
            default: rdata = '0;
        endcase
    end

    assign btn_irq = pending & enable;  // Masked interrupts

endmodule

`default_nettype wire

// ==== hw/soc_periph_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defines.svh"

module soc_periph_top (
    input  logic                    sysclk,
    input  logic                    RSTn,
    // APB slave port
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`ADDR_WIDTH-1:0]  paddr,
    input  logic [`DATA_WIDTH-1:0]  pwdata,
    output logic [`DATA_WIDTH-1:0]  prdata,
    output logic                    pready,
    output logic                    pslverr,
    // Pins
    inout  wire  [`GPIO_WIDTH-1:0]  gpio,
    input  logic                    uart_rxd,
    output logic                    uart_txd,
    input  logic [`BTN_WIDTH-1:0]   btn,
    output logic [`IRQ_WIDTH-1:0]   irq
);

    logic                   gpio_sel, uart_sel, btn_sel;
    logic [`DATA_WIDTH-1:0] gpio_rdata, uart_rdata, btn_rdata;
    logic                   uart_err;
    logic                   uart_rx_valid;
    logic [`BTN_WIDTH-1:0]  btn_irq;

    // -------------------------------------------------------------------------
    // Address decode and read return
    // -------------------------------------------------------------------------
    apb_decoder u_apb_decoder (
        .psel       (psel),
        .penable    (penable),
        .region     (paddr[`REGION_MSB:`REGION_LSB]),
        .gpio_rdata (gpio_rdata),
        .uart_rdata (uart_rdata),
        .uart_err   (uart_err),
        .btn_rdata  (btn_rdata),
        .gpio_sel   (gpio_sel),
        .uart_sel   (uart_sel),
        .btn_sel    (btn_sel),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr)
    );

    // -------------------------------------------------------------------------
    // Peripherals
    // -------------------------------------------------------------------------
    gpio_port u_gpio_port (
        .sysclk  (sysclk),
        .RSTn    (RSTn),
        .sel     (gpio_sel),
        .penable (penable),
        .pwrite  (pwrite),
        .addr    (paddr[7:0]),
        .wdata   (pwdata),
        .rdata   (gpio_rdata),
        .gpio    (gpio)
    );

    uart_core u_uart_core (
        .sysclk   (sysclk),
        .RSTn     (RSTn),
        .sel      (uart_sel),
        .penable  (penable),
        .pwrite   (pwrite),
        .addr     (paddr[7:0]),
        .wdata    (pwdata),
        .rdata    (uart_rdata),
        .err      (uart_err),
        .rxd      (uart_rxd),
        .txd      (uart_txd),
        .rx_valid (uart_rx_valid)
    );

    button_irq u_button_irq (
        .sysclk  (sysclk),
        .RSTn    (RSTn),
        .sel     (btn_sel),
        .penable (penable),
        .pwrite  (pwrite),
        .addr    (paddr[7:0]),
        .wdata   (pwdata),
        .rdata   (btn_rdata),
        .btn     (btn),
        .btn_irq (btn_irq)
    );

    // Buttons in the low bits, UART receive on top
    assign irq[`BTN_WIDTH-1:0] = btn_irq;
    assign irq[`IRQ_UART_RX]   = uart_rx_valid;

endmodule

`default_nettype wire

// ==== soc_periph.f ====
+incdir+common
common/soc_periph_pkg.sv
hw/apb_decoder.sv
hw/button_irq.sv
gpio/gpio_port.sv
uart/uart_core.sv
hw/soc_periph_top.sv
tests/soc_periph_assertions.sv
tests/soc_periph_tb.sv

// ==== tests/soc_periph_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defines.svh"

module soc_periph_assertions (
    input logic                  sysclk,
    input logic                  RSTn,
    input logic                  psel,
    input logic                  penable,
    input logic                  pready,
    input logic                  pslverr,
    input logic [`IRQ_WIDTH-1:0] irq
);

    int unsigned assert_fails = 0;

    // No wait states on this bus
    a_pready_high: assert property (@(posedge sysclk) disable iff (!RSTn) pready)
        else begin
            $error("pready dropped low");
            assert_fails++;
        end

    a_pslverr_access: assert property (
        @(posedge sysclk) disable iff (!RSTn) pslverr |-> (psel && penable))
        else begin
            $error("pslverr high outside an access cycle");
            assert_fails++;
        end

    // Interrupts quiet while held in reset
    a_irq_reset: assert property (@(posedge sysclk) !RSTn |-> (irq == '0))
        else begin
            $error("irq active during reset");
            assert_fails++;
        end

endmodule

bind soc_periph_top soc_periph_assertions u_soc_periph_assertions (.*);

`default_nettype wire

// ==== tests/soc_periph_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defines.svh"

module soc_periph_tb;

    import soc_periph_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int BAUD_TB      = 8;            // Divisor used by the serial tests
    localparam int FRAME_CYCLES = 10 * BAUD_TB;
    localparam int APB_CYCLES   = 3;            // Setup, access, idle
    localparam int POLL_LIMIT   = 64;
    localparam int TEST_CYCLES  = RESET_CYCLES + 3 * FRAME_CYCLES
                                + 2 * POLL_LIMIT * APB_CYCLES + 30 * APB_CYCLES + 40;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

    logic                   sysclk;
    logic                   RSTn;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`ADDR_WIDTH-1:0] paddr;
    logic [`DATA_WIDTH-1:0] pwdata;
    logic [`DATA_WIDTH-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
    wire  [`GPIO_WIDTH-1:0] gpio;
    logic                   uart_rxd;
    logic                   uart_txd;
    logic [`BTN_WIDTH-1:0]  btn;
    logic [`IRQ_WIDTH-1:0]  irq;

    // External driver on the upper GPIO byte
    logic       gpio_hi_en;
    logic [7:0] gpio_hi_val;

    integer seed         = 82288;
    int     errors       = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;

    soc_periph_top u_soc_periph_top (
        .sysclk   (sysclk),
        .RSTn     (RSTn),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .gpio     (gpio),
        .uart_rxd (uart_rxd),
        .uart_txd (uart_txd),
        .btn      (btn),
        .irq      (irq)
    );

    assign gpio[`GPIO_WIDTH-1:8] = gpio_hi_en ? gpio_hi_val : 8'hzz;

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;   // 20 ns period
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sysclk);
        $display("Watchdog expired after %0d cycles, the tests did not complete",
                 WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    // -------------------------------------------------------------------------
    // Helpers
    // -------------------------------------------------------------------------
    function automatic logic [`ADDR_WIDTH-1:0] reg_addr(periph_sel_e region, reg_off_e off);
        logic [`ADDR_WIDTH-1:0] a;
        a = '0;
        a[`REGION_MSB:`REGION_LSB] = region;
        a[7:0] = off;
        return a;
    endfunction

    task automatic check_equal(input string name, input logic [`DATA_WIDTH-1:0] exp,
                               input logic [`DATA_WIDTH-1:0] act);
        assert (act === exp)
        else begin
            $display("** Error: %s expected 0x%08h actual 0x%08h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1)
        else begin
            $display("Failure at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("%-16s ok", name);
        end else begin
            $display("%-16s %0d check(s) failed", name, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    // -------------------------------------------------------------------------
    // APB master, two cycles per transfer
    // -------------------------------------------------------------------------
    task automatic apb_write(input logic [`ADDR_WIDTH-1:0] addr,
                             input logic [`DATA_WIDTH-1:0] data, output logic err);
        @(posedge sysclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge sysclk);
        penable <= 1'b1;
        @(negedge sysclk);
        err = pslverr;      // Valid in the access cycle
        @(posedge sysclk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [`ADDR_WIDTH-1:0] addr,
                            output logic [`DATA_WIDTH-1:0] data, output logic err);
        @(posedge sysclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge sysclk);
        penable <= 1'b1;
        @(negedge sysclk);
        data = prdata;
        err  = pslverr;
        @(posedge sysclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic poll_uart_status(input int bit_idx, input logic value, output logic seen);
        logic [`DATA_WIDTH-1:0] status;
        logic                   err;
        int                     polls;
        seen  = 1'b0;
        polls = 0;
        while (!seen && polls < POLL_LIMIT) begin
            apb_read(reg_addr(SEL_UART, REG_1), status, err);
            seen = (status[bit_idx] === value);
            polls++;
        end
    endtask

    // -------------------------------------------------------------------------
    // Serial line model, 8N1 at BAUD_TB clocks per bit
    // -------------------------------------------------------------------------
    task automatic send_serial(input logic [7:0] data);
        @(posedge sysclk);
        uart_rxd <= 1'b0;                           // Start bit
        repeat (BAUD_TB) @(posedge sysclk);
        for (int i = 0; i < 8; i++) begin
            uart_rxd <= data[i];
            repeat (BAUD_TB) @(posedge sysclk);
        end
        uart_rxd <= 1'b1;                           // Stop bit
        repeat (BAUD_TB) @(posedge sysclk);
    endtask

    task automatic receive_serial(input string name, output logic [7:0] data,
                                  output logic found);
        int waited;
        waited = 0;
        data   = '0;
        @(negedge sysclk);
        while (uart_txd !== 1'b0 && waited < FRAME_CYCLES) begin
            @(negedge sysclk);
            waited++;
        end
        found = (uart_txd === 1'b0);
        if (found) begin
            repeat (BAUD_TB / 2) @(negedge sysclk);    // Middle of start bit
            check_equal({name, " start bit"}, 0, uart_txd);
            for (int i = 0; i < 8; i++) begin
                repeat (BAUD_TB) @(negedge sysclk);
                data[i] = uart_txd;                 // LSB first
            end
            repeat (BAUD_TB) @(negedge sysclk);
            check_equal({name, " stop bit"}, 1, uart_txd);
        end
    endtask

    // -------------------------------------------------------------------------
    // Directed tests
    // -------------------------------------------------------------------------
    task automatic test_reset_and_hole();
        logic [`DATA_WIDTH-1:0] rd;
        logic                   err;
        int                     errors_at_start;
        errors_at_start = errors;
        @(negedge sysclk);
        check_equal("reset irq", 0, irq);
        check_equal("reset uart_txd", 1, uart_txd);
        check_equal("reset gpio released", 32'h0000_zzzz, {16'h0, gpio});
        apb_read(reg_addr(SEL_NONE, REG_0), rd, err);
        check_equal("hole pslverr", 1, err);
        check_equal("hole prdata", 0, rd);
        finish_test("reset_and_hole", errors_at_start);
    endtask

    task automatic test_gpio();
        logic [`DATA_WIDTH-1:0] rd;
        logic                   err;
        logic [15:0]            data;
        logic [7:0]             hi;
        int                     errors_at_start;
        errors_at_start = errors;
        data = 16'($random(seed));
        apb_write(reg_addr(SEL_GPIO, REG_0), {16'h0, data}, err);
        apb_write(reg_addr(SEL_GPIO, REG_1), 32'h0000_00ff, err);
        @(negedge sysclk);
        check_equal("gpio low pins", data[7:0], gpio[7:0]);
        hi = 8'($random(seed));
        @(posedge sysclk);
        gpio_hi_val <= hi;
        gpio_hi_en  <= 1'b1;
        repeat (3) @(posedge sysclk);               // Through the synchronizer
        apb_read(reg_addr(SEL_GPIO, REG_2), rd, err);
        check_equal("gpio data_in", {16'h0, hi, data[7:0]}, rd);
        @(posedge sysclk);
        gpio_hi_en <= 1'b0;
        finish_test("gpio", errors_at_start);
    endtask

    task automatic test_uart_tx();
        logic [`DATA_WIDTH-1:0] rd;
        logic                   err;
        logic                   busy_err;
        logic [7:0]             tx_byte;
        logic [7:0]             got;
        logic                   found;
        logic                   idle;
        int                     errors_at_start;
        errors_at_start = errors;
        apb_write(reg_addr(SEL_UART, REG_2), BAUD_TB, err);
        apb_read(reg_addr(SEL_UART, REG_2), rd, err);
        check_equal("uart bauddiv", BAUD_TB, rd);
        tx_byte = 8'($random(seed));
        apb_write(reg_addr(SEL_UART, REG_0), {24'h0, tx_byte}, err);
        check_equal("uart tx write pslverr", 0, err);
        fork
            receive_serial("uart_tx", got, found);
            begin
                apb_read(reg_addr(SEL_UART, REG_1), rd, err);
                check_equal("uart tx_busy", 1, rd[0]);
                // Dropped, frame on the line stays intact
                apb_write(reg_addr(SEL_UART, REG_0), {24'h0, ~tx_byte}, busy_err);
                check_equal("uart busy write pslverr", 1, busy_err);
            end
        join
        check_true(found, "no start bit seen on uart_txd");
        if (found)
            check_equal("uart tx byte", tx_byte, got);
        poll_uart_status(0, 1'b0, idle);
        check_true(idle, "uart tx_busy never cleared after the frame");
        finish_test("uart_tx", errors_at_start);
    endtask

    task automatic test_uart_rx();
        logic [`DATA_WIDTH-1:0] rd;
        logic                   err;
        logic [7:0]             rx_byte;
        logic                   seen;
        int                     errors_at_start;
        errors_at_start = errors;
        rx_byte = 8'($random(seed));
        send_serial(rx_byte);
        poll_uart_status(1, 1'b1, seen);
        check_true(seen, "uart rx_valid never set after a frame was sent");
        @(negedge sysclk);
        check_equal("uart rx irq", 1, irq[`IRQ_UART_RX]);
        apb_read(reg_addr(SEL_UART, REG_0), rd, err);
        check_equal("uart rx byte", {24'h0, rx_byte}, rd);
        apb_read(reg_addr(SEL_UART, REG_1), rd, err);
        check_equal("uart rx_valid cleared", 0, rd[1]);
        @(negedge sysclk);
        check_equal("uart rx irq cleared", 0, irq[`IRQ_UART_RX]);
        finish_test("uart_rx", errors_at_start);
    endtask

    task automatic test_buttons();
        logic [`DATA_WIDTH-1:0] rd;
        logic                   err;
        int                     errors_at_start;
        errors_at_start = errors;
        apb_write(reg_addr(SEL_BTN, REG_2), 32'h5, err);
        @(posedge sysclk);
        btn <= '1;
        repeat (4) @(posedge sysclk);
        btn <= '0;
        repeat (3) @(posedge sysclk);
        apb_read(reg_addr(SEL_BTN, REG_1), rd, err);
        check_equal("btn pending all", 32'hf, rd);
        @(negedge sysclk);
        check_equal("btn irq masked", 4'b0101, irq[`BTN_WIDTH-1:0]);
        apb_write(reg_addr(SEL_BTN, REG_1), 32'h1, err);   // Clear button 0
        apb_read(reg_addr(SEL_BTN, REG_1), rd, err);
        check_equal("btn pending cleared", 32'he, rd);
        @(negedge sysclk);
        check_equal("btn irq after clear", 4'b0100, irq[`BTN_WIDTH-1:0]);
        finish_test("buttons", errors_at_start);
    endtask

    // -------------------------------------------------------------------------
    // Sequence
    // -------------------------------------------------------------------------
    initial begin
        int bound_fails;
        RSTn        = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        uart_rxd    = 1'b1;     // Line idle
        btn         = '0;
        gpio_hi_en  = 1'b0;
        gpio_hi_val = '0;
        repeat (RESET_CYCLES) @(posedge sysclk);
        RSTn <= 1'b1;

        test_reset_and_hole();
        test_gpio();
        test_uart_tx();
        test_uart_rx();
        test_buttons();

        bound_fails = u_soc_periph_top.u_soc_periph_assertions.assert_fails;
        $display("Summary: %0d tests run, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, bound_fails);
        if (tests_failed == 0 && errors == 0 && bound_fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== uart/uart_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defines.svh"

module uart_core (
    input  logic                   sysclk,
    input  logic                   RSTn,
    input  logic                   sel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             addr,
    input  logic [`DATA_WIDTH-1:0] wdata,
    output logic [`DATA_WIDTH-1:0] rdata,
    output logic                   err,
    input  logic                   rxd,
    output logic                   txd,
    output logic                   rx_valid
);

    import soc_periph_pkg::*;

    // REG_0 TXDATA/RXDATA, REG_1 STATUS, REG_2 BAUDDIV
    logic [`UART_BAUDDIV_WIDTH-1:0] baud_div;
    logic                           tx_wr, rx_rd, bauddiv_wr;

    // Transmit state
    logic                           tx_busy;
    logic [9:0]                     tx_shift;       // Stop, data, start
    logic [3:0]                     tx_bit_cnt;
    logic [`UART_BAUDDIV_WIDTH-1:0] tx_baud_cnt;

    // Receive state
    logic [1:0]                     rx_sync;
    logic                           rx_busy;
    logic [3:0]                     rx_bit_cnt;
    logic [`UART_BAUDDIV_WIDTH-1:0] rx_baud_cnt;
    logic [7:0]                     rx_shift;
    logic [7:0]                     rx_data;

    assign tx_wr      = sel && penable && pwrite && (addr == REG_0);
    assign rx_rd      = sel && penable && !pwrite && (addr == REG_0);
    assign bauddiv_wr = sel && penable && pwrite && (addr == REG_2);

    // Byte written while a frame is still going out is dropped
    assign err = tx_wr && tx_busy;

    always_ff @(posedge sysclk or negedge RSTn) begin
        if (!RSTn)
            baud_div <= `UART_BAUDDIV_WIDTH'(`UART_BAUDDIV_RESET);
        else if (bauddiv_wr)
            baud_div <= wdata[`UART_BAUDDIV_WIDTH-1:0];
    end

    // -------------------------------------------------------------------------
    // Transmitter
    // -------------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge RSTn) begin
        if (!RSTn) begin
            tx_busy     <= 1'b0;
            tx_shift    <= '1;
            tx_bit_cnt  <= '0;
            tx_baud_cnt <= '0;
        end else if (!tx_busy) begin
            if (tx_wr) begin
                tx_busy     <= 1'b1;
                tx_shift    <= {1'b1, wdata[7:0], 1'b0};
                tx_bit_cnt  <= '0;
                tx_baud_cnt <= '0;
            end
        end else if (tx_baud_cnt == baud_div - 1'b1) begin
            tx_baud_cnt <= '0;
            tx_shift    <= {1'b1, tx_shift[9:1]};
            tx_bit_cnt  <= tx_bit_cnt + 1'b1;
            if (tx_bit_cnt == 4'd9)             // Stop bit done
                tx_busy <= 1'b0;
        end else begin
            tx_baud_cnt <= tx_baud_cnt + 1'b1;
        end
    end

    assign txd = tx_busy ? tx_shift[0] : 1'b1;     // Idle high

    // -------------------------------------------------------------------------
    // Receiver
    // -------------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge RSTn) begin
        if (!RSTn) begin
            rx_sync     <= 2'b11;
            rx_busy     <= 1'b0;
            rx_bit_cnt  <= '0;
            rx_baud_cnt <= '0;
            rx_valid    <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], rxd};
            if (rx_rd)
                rx_valid <= 1'b0;
            if (!rx_busy) begin
                if (!rx_sync[1]) begin          // Falling edge of start bit
                    rx_busy     <= 1'b1;
                    rx_bit_cnt  <= '0;
                    rx_baud_cnt <= baud_div >> 1;   // Half period to mid-bit
                end
            end else if (rx_baud_cnt == baud_div - 1'b1) begin
                rx_baud_cnt <= '0;
                rx_bit_cnt  <= rx_bit_cnt + 1'b1;
                if (rx_bit_cnt == 4'd0 && rx_sync[1])
                    rx_busy <= 1'b0;            // Glitch, not a start bit
                if (rx_bit_cnt == 4'd9) begin
                    rx_busy <= 1'b0;
                    if (rx_sync[1])
                        rx_valid <= 1'b1;       // Good stop bit
                end
            end else begin
                rx_baud_cnt <= rx_baud_cnt + 1'b1;
            end
        end
    end

    // Data path, LSB first
    always_ff @(posedge sysclk) begin
        if (rx_busy && rx_baud_cnt == baud_div - 1'b1) begin
            if (rx_bit_cnt >= 4'd1 && rx_bit_cnt <= 4'd8)
                rx_shift <= {rx_sync[1], rx_shift[7:1]};
            if (rx_bit_cnt == 4'd9 && rx_sync[1])
                rx_data <= rx_shift;
        end
    end

    // -------------------------------------------------------------------------
    // Read mux
    // -------------------------------------------------------------------------
    always_comb begin
        rdata = '0;
        case (addr)
            REG_0:   rdata[7:0] = rx_data;
            REG_1:   rdata[1:0] = {rx_valid, tx_busy};
            REG_2:   rdata[`UART_BAUDDIV_WIDTH-1:0] = baud_div;
            default: rdata = '0;
        endcase
    end

endmodule

`default_nettype wire
